// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := aou_tb
FILELIST := aou_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== aou_top.f ====
design/apb_pkg.sv
design/aou_pkg.sv
design/apb_reg_port.sv
design/aou_gpio.sv
design/aou_rtc.sv
design/aou_pmu.sv
design/aou_top.sv
tb/aou_checker.sv
tb/aou_tb.sv

// ==== design/aou_gpio.sv ====
/*
 * 32-bit GPIO port: data, direction and interrupt-enable registers,
 * input synchronizer, rising-edge interrupt status and pad enables.
 */
`timescale 1ns/100ps
`default_nettype none

module aou_gpio (
  input  logic                       pclk,
  input  logic                       rst,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [apb_pkg::addr_w-1:0] paddr,
  input  apb_pkg::data_t             pwdata,
  input  logic [aou_pkg::gpio_w-1:0] ext_porta,
  output apb_pkg::data_t             prdata,
  output logic [aou_pkg::gpio_w-1:0] porta_dr,
  output logic [aou_pkg::gpio_w-1:0] pad_gpio_oen,
  output logic [aou_pkg::gpio_w-1:0] pad_gpio_ien,
  output logic                       gpio_intr
);

  logic                       wr_stb;
  logic                       rd_stb;
  logic                       reg_valid;
  aou_pkg::gpio_reg_t         reg_idx;
  logic                       wr_en;
  logic [aou_pkg::gpio_w-1:0] wdata;
  logic [aou_pkg::gpio_w-1:0] porta_ddr;
  logic [aou_pkg::gpio_w-1:0] inten;
  logic [aou_pkg::gpio_w-1:0] intstat;
  logic [aou_pkg::gpio_w-1:0] stat_clr;
  logic [aou_pkg::gpio_w-1:0] ext_meta;
  logic [aou_pkg::gpio_w-1:0] ext_sync;
  logic [aou_pkg::gpio_w-1:0] ext_prev;
  logic [aou_pkg::gpio_w-1:0] rise;

  apb_reg_port #(.reg_idx_t(aou_pkg::gpio_reg_t)) x_reg_port (
    .pclk      (pclk     ),
    .rst       (rst      ),
    .psel      (psel     ),
    .penable   (penable  ),
    .pwrite    (pwrite   ),
    .paddr     (paddr    ),
    .wr_stb    (wr_stb   ),
    .rd_stb    (rd_stb   ),
    .reg_idx   (reg_idx  ),
    .reg_valid (reg_valid)
  );

  assign wr_en = wr_stb && reg_valid;
  assign wdata = pwdata[aou_pkg::gpio_w-1:0];

  always_ff @(posedge pclk) begin
    if (rst) begin
      porta_dr  <= '0;
      porta_ddr <= '0;
      inten     <= '0;
    end else if (wr_en) begin
      case (reg_idx)
        aou_pkg::gpio_dr:    porta_dr  <= wdata;
        aou_pkg::gpio_ddr:   porta_ddr <= wdata;
        aou_pkg::gpio_inten: inten     <= wdata;
        default: ;
      endcase
    end
  end

  // Two flops against metastability, a third to find rising edges.
  always_ff @(posedge pclk) begin
    ext_meta <= ext_porta;
    ext_sync <= ext_meta;
    ext_prev <= ext_sync;
  end

  assign rise     = ext_sync & ~ext_prev;
  assign stat_clr = (wr_en && reg_idx == aou_pkg::gpio_intstat) ? wdata : '0;

  always_ff @(posedge pclk) begin
    if (rst) begin
      intstat <= '0;
    end else begin
      intstat <= (intstat & ~stat_clr) | (rise & inten);   // New edges win over a clear.
    end
  end

  always_comb begin
    prdata = '0;
    if (rd_stb && reg_valid) begin
      case (reg_idx)
        aou_pkg::gpio_dr:      prdata = apb_pkg::data_t'(porta_dr);
        aou_pkg::gpio_ddr:     prdata = apb_pkg::data_t'(porta_ddr);
        aou_pkg::gpio_inten:   prdata = apb_pkg::data_t'(inten);
        aou_pkg::gpio_ext:     prdata = apb_pkg::data_t'(ext_sync);
        aou_pkg::gpio_intstat: prdata = apb_pkg::data_t'(intstat);
        default:               prdata = '0;
      endcase
    end
  end

  assign pad_gpio_oen = ~porta_ddr;                     // Output driver on where ddr is 1.
  assign pad_gpio_ien = porta_ddr;
  assign gpio_intr    = |intstat;

endmodule

`default_nettype wire

// ==== design/aou_pkg.sv ====
/*
 * Register maps of the always-on slaves: GPIO, real-time counter and PMU.
 * Register offsets are the enumeration value times four.
 */
`default_nettype none

package aou_pkg;

  typedef enum logic [apb_pkg::reg_bits-1:0] {
    gpio_dr, gpio_ddr, gpio_inten, gpio_ext, gpio_intstat
  } gpio_reg_t;

  typedef enum logic [apb_pkg::reg_bits-1:0] {
    rtc_count, rtc_match, rtc_ctrl, rtc_intstat
  } rtc_reg_t;

  typedef enum logic [apb_pkg::reg_bits-1:0] {
    pmu_clk_en, pmu_dfs, pmu_wake
  } pmu_reg_t;

  localparam int gpio_w = 32;

  localparam int rtc_prescale = 4;                      // Pclk cycles per counter tick.
  localparam int rtc_presc_w  = $clog2(rtc_prescale);
  localparam int rtc_ctrl_en  = 0;
  localparam int rtc_ctrl_ie  = 1;

  localparam int pmu_en_apb0 = 0;
  localparam int pmu_en_apb1 = 1;

endpackage

`default_nettype wire

// ==== design/aou_pmu.sv ====
/*
 * Power management: bus clock enables, CPU frequency-change
 * request and acknowledge, and the wake interrupt.
 */
`timescale 1ns/100ps
`default_nettype none

module aou_pmu (
  input  logic                       pclk,
  input  logic                       rst,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [apb_pkg::addr_w-1:0] paddr,
  input  apb_pkg::data_t             pwdata,
  input  logic                       gpio_intr,
  input  logic                       rtc_intr,
  input  logic                       cpu_pmu_sleep_b,
  input  logic                       cpu_pmu_dfs_ack,
  output apb_pkg::data_t             prdata,
  output logic                       pmu_apb0_pclk_en,
  output logic                       pmu_apb1_pclk_en,
  output logic                       pmu_cpu_dfs_req,
  output logic                       pmu_wic_intr
);

  logic              wr_stb;
  logic              rd_stb;
  logic              reg_valid;
  aou_pkg::pmu_reg_t reg_idx;
  logic              wr_en;
  logic [1:0]        clk_en;
  logic              wake;

  apb_reg_port #(.reg_idx_t(aou_pkg::pmu_reg_t)) x_reg_port (
    .pclk      (pclk     ),
    .rst       (rst      ),
    .psel      (psel     ),
    .penable   (penable  ),
    .pwrite    (pwrite   ),
    .paddr     (paddr    ),
    .wr_stb    (wr_stb   ),
    .rd_stb    (rd_stb   ),
    .reg_idx   (reg_idx  ),
    .reg_valid (reg_valid)
  );

  assign wr_en = wr_stb && reg_valid;

  always_ff @(posedge pclk) begin
    if (rst) begin
      clk_en          <= 2'b11;                         // Both buses clocked out of reset.
      pmu_cpu_dfs_req <= 1'b0;
      wake            <= 1'b0;
    end else begin
      if (wr_en && reg_idx == aou_pkg::pmu_clk_en) begin
        clk_en <= pwdata[1:0];
      end
      if (wr_en && reg_idx == aou_pkg::pmu_dfs && pwdata[0]) begin
        pmu_cpu_dfs_req <= 1'b1;
      end else if (cpu_pmu_dfs_ack) begin
        pmu_cpu_dfs_req <= 1'b0;                        // CPU has switched its clock.
      end
      if (!cpu_pmu_sleep_b && (gpio_intr || rtc_intr)) begin
        wake <= 1'b1;
      end else if (wr_en && reg_idx == aou_pkg::pmu_wake && pwdata[0]) begin
        wake <= 1'b0;
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (rd_stb && reg_valid) begin
      case (reg_idx)
        aou_pkg::pmu_clk_en: prdata = apb_pkg::data_t'(clk_en);
        aou_pkg::pmu_dfs:    prdata = apb_pkg::data_t'({pmu_cpu_dfs_req, 1'b0});
        aou_pkg::pmu_wake:   prdata = apb_pkg::data_t'(wake);
        default:             prdata = '0;
      endcase
    end
  end

  assign pmu_apb0_pclk_en = clk_en[aou_pkg::pmu_en_apb0];
  assign pmu_apb1_pclk_en = clk_en[aou_pkg::pmu_en_apb1];
  assign pmu_wic_intr     = wake;

endmodule

`default_nettype wire

// ==== design/aou_rtc.sv ====
/*
 * Real-time counter: prescaler, 32-bit count, match compare,
 * control bits and match interrupt status.
 */
`timescale 1ns/100ps
`default_nettype none

module aou_rtc (
  input  logic                       pclk,
  input  logic                       rst,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [apb_pkg::addr_w-1:0] paddr,
  input  apb_pkg::data_t             pwdata,
  output apb_pkg::data_t             prdata,
  output logic                       rtc_intr
);

  logic                            wr_stb;
  logic                            rd_stb;
  logic                            reg_valid;
  aou_pkg::rtc_reg_t               reg_idx;
  logic                            wr_en;
  logic [aou_pkg::rtc_presc_w-1:0] presc;
  logic                            tick;
  apb_pkg::data_t                  count;
  apb_pkg::data_t                  match;
  logic [1:0]                      ctrl;
  logic                            intstat;
  logic                            stat_clr;

  apb_reg_port #(.reg_idx_t(aou_pkg::rtc_reg_t)) x_reg_port (
    .pclk      (pclk     ),
    .rst       (rst      ),
    .psel      (psel     ),
    .penable   (penable  ),
    .pwrite    (pwrite   ),
    .paddr     (paddr    ),
    .wr_stb    (wr_stb   ),
    .rd_stb    (rd_stb   ),
    .reg_idx   (reg_idx  ),
    .reg_valid (reg_valid)
  );

  assign wr_en = wr_stb && reg_valid;
  assign tick  = ctrl[aou_pkg::rtc_ctrl_en]
              && presc == aou_pkg::rtc_presc_w'(aou_pkg::rtc_prescale - 1);

  always_ff @(posedge pclk) begin
    if (rst || !ctrl[aou_pkg::rtc_ctrl_en]) begin
      presc <= '0;                                      // Restarts a full period on enable.
    end else begin
      presc <= presc + 1'b1;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      count <= '0;
      match <= '0;
      ctrl  <= '0;
    end else begin
      if (wr_en && reg_idx == aou_pkg::rtc_count) begin
        count <= pwdata;
      end else if (tick) begin
        count <= count + 1'b1;
      end
      if (wr_en && reg_idx == aou_pkg::rtc_match) begin
        match <= pwdata;
      end
      if (wr_en && reg_idx == aou_pkg::rtc_ctrl) begin
        ctrl[aou_pkg::rtc_ctrl_en] <= pwdata[aou_pkg::rtc_ctrl_en];
        ctrl[aou_pkg::rtc_ctrl_ie] <= pwdata[aou_pkg::rtc_ctrl_ie];
      end
    end
  end

  assign stat_clr = wr_en && reg_idx == aou_pkg::rtc_intstat && pwdata[0];

  always_ff @(posedge pclk) begin
    if (rst) begin
      intstat <= 1'b0;
    end else if (tick && count == match) begin
      intstat <= 1'b1;
    end else if (stat_clr) begin
      intstat <= 1'b0;
    end
  end

  always_comb begin
    prdata = '0;
    if (rd_stb && reg_valid) begin
      case (reg_idx)
        aou_pkg::rtc_count:   prdata = count;
        aou_pkg::rtc_match:   prdata = match;
        aou_pkg::rtc_ctrl:    prdata = apb_pkg::data_t'(ctrl);
        aou_pkg::rtc_intstat: prdata = apb_pkg::data_t'(intstat);
        default:              prdata = '0;
      endcase
    end
  end

  assign rtc_intr = intstat && ctrl[aou_pkg::rtc_ctrl_ie];

endmodule

`default_nettype wire

// ==== design/aou_top.sv ====
/*
 * Always-on domain top level. The APB bus fans out to the GPIO,
 * real-time counter and PMU slaves, each with its own select and read data.
 */
`timescale 1ns/100ps
`default_nettype none

module aou_top (
  input  logic                       pclk,
  input  logic                       rst,
  input  logic [apb_pkg::addr_w-1:0] paddr,
  input  apb_pkg::data_t             pwdata,
  input  logic                       pwrite,
  input  logic                       penable,
  input  logic                       gpio_psel,
  input  logic                       rtc_psel,
  input  logic                       pmu_psel,
  output apb_pkg::data_t             gpio_prdata,
  output apb_pkg::data_t             rtc_prdata,
  output apb_pkg::data_t             pmu_prdata,
  input  logic [aou_pkg::gpio_w-1:0] ioctl_gpio_ext_porta,
  output logic [aou_pkg::gpio_w-1:0] gpio_ioctl_porta_dr,
  output logic [aou_pkg::gpio_w-1:0] pad_gpio_oen,
  output logic [aou_pkg::gpio_w-1:0] pad_gpio_ien,
  output logic                       gpio_wic_intr,
  output logic                       rtc_wic_intr,
  output logic                       pmu_wic_intr,
  input  logic                       cpu_pmu_sleep_b,
  input  logic                       cpu_pmu_dfs_ack,
  output logic                       pmu_cpu_dfs_req,
  output logic                       pmu_apb0_pclk_en,
  output logic                       pmu_apb1_pclk_en
);

  aou_gpio x_gpio (
    .pclk         (pclk                ),
    .rst          (rst                 ),
    .psel         (gpio_psel           ),
    .penable      (penable             ),
    .pwrite       (pwrite              ),
    .paddr        (paddr               ),
    .pwdata       (pwdata              ),
    .ext_porta    (ioctl_gpio_ext_porta),
    .prdata       (gpio_prdata         ),
    .porta_dr     (gpio_ioctl_porta_dr ),
    .pad_gpio_oen (pad_gpio_oen        ),
    .pad_gpio_ien (pad_gpio_ien        ),
    .gpio_intr    (gpio_wic_intr       )
  );

  aou_rtc x_rtc (
    .pclk     (pclk        ),
    .rst      (rst         ),
    .psel     (rtc_psel    ),
    .penable  (penable     ),
    .pwrite   (pwrite      ),
    .paddr    (paddr       ),
    .pwdata   (pwdata      ),
    .prdata   (rtc_prdata  ),
    .rtc_intr (rtc_wic_intr)
  );

  // Both slave interrupts also feed the wake logic.
  aou_pmu x_pmu (
    .pclk             (pclk            ),
    .rst              (rst             ),
    .psel             (pmu_psel        ),
    .penable          (penable         ),
    .pwrite           (pwrite          ),
    .paddr            (paddr           ),
    .pwdata           (pwdata          ),
    .gpio_intr        (gpio_wic_intr   ),
    .rtc_intr         (rtc_wic_intr    ),
    .cpu_pmu_sleep_b  (cpu_pmu_sleep_b ),
    .cpu_pmu_dfs_ack  (cpu_pmu_dfs_ack ),
    .prdata           (pmu_prdata      ),
    .pmu_apb0_pclk_en (pmu_apb0_pclk_en),
    .pmu_apb1_pclk_en (pmu_apb1_pclk_en),
    .pmu_cpu_dfs_req  (pmu_cpu_dfs_req ),
    .pmu_wic_intr     (pmu_wic_intr    )
  );

endmodule

`default_nettype wire

// ==== design/apb_pkg.sv ====
/*
 * APB bus parameters: address and data widths, the address bits
 * that select a register, and the bus word type.
 */
`default_nettype none

package apb_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;

  // Byte offset bits below reg_lsb are ignored, since all registers are words.
  localparam int reg_lsb  = 2;
  localparam int reg_bits = 3;

  typedef logic [data_w-1:0] data_t;

endpackage

`default_nettype wire

// ==== design/apb_reg_port.sv ====
/*
 * APB slave front end shared by all register maps. Latches the register
 * index in the setup cycle and raises read or write strobes in the access cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module apb_reg_port #(
  parameter type reg_idx_t = aou_pkg::gpio_reg_t
) (
  input  logic                       pclk,
  input  logic                       rst,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [apb_pkg::addr_w-1:0] paddr,
  output logic                       wr_stb,
  output logic                       rd_stb,
  output reg_idx_t                   reg_idx,
  output logic                       reg_valid
);

  logic [apb_pkg::reg_bits-1:0] offset;
  logic                         setup;
  logic                         access;

  // Each register map decides its own legal offsets through its enumeration.
  function automatic logic idx_defined(logic [apb_pkg::reg_bits-1:0] raw);
    reg_idx_t probe;
    logic     hit;
    hit   = 1'b0;
    probe = probe.first();
    for (int i = 0; i < probe.num(); i++) begin
      if (raw == probe) hit = 1'b1;
      probe = probe.next();
    end
    return hit;
  endfunction

  assign offset = paddr[apb_pkg::reg_lsb +: apb_pkg::reg_bits];
  assign setup  = psel && !penable;
  assign access = psel && penable;

  always_ff @(posedge pclk) begin
    if (rst) begin
      reg_valid <= 1'b0;
    end else if (setup) begin
      reg_valid <= idx_defined(offset);
    end
  end

  always_ff @(posedge pclk) begin
    if (setup) begin
      reg_idx <= reg_idx_t'(offset);
    end
  end

  assign wr_stb = access && pwrite;                     // Write lands on the edge ending access.
  assign rd_stb = access && !pwrite;

endmodule

`default_nettype wire

// ==== tb/aou_checker.sv ====
/*
 * Checker for the always-on domain testbench. Selects a watched DUT
 * output, compares it on request and keeps the check and error counts.
 */
`timescale 1ns/100ps
`default_nettype none

module aou_checker (
  input  logic                       pclk,
  input  logic                       chk_req,
  input  int                         chk_id,
  input  int                         chk_sig,
  input  logic [31:0]                chk_exp,
  input  logic                       chk_ge,
  input  apb_pkg::data_t             gpio_prdata,
  input  apb_pkg::data_t             rtc_prdata,
  input  apb_pkg::data_t             pmu_prdata,
  input  logic                       gpio_wic_intr,
  input  logic                       rtc_wic_intr,
  input  logic                       pmu_wic_intr,
  input  logic                       pmu_cpu_dfs_req,
  input  logic                       pmu_apb0_pclk_en,
  input  logic                       pmu_apb1_pclk_en,
  input  logic [aou_pkg::gpio_w-1:0] gpio_ioctl_porta_dr,
  input  logic [aou_pkg::gpio_w-1:0] pad_gpio_oen,
  input  logic [aou_pkg::gpio_w-1:0] pad_gpio_ien,
  output logic [31:0]                watch_val,
  output int                         n_checks,
  output int                         n_errors
);

  int   checks = 0;
  int   errors = 0;
  logic ok;

  function automatic string sig_name(input int code);
    case (code)
      0:       return "gpio_prdata";
      1:       return "rtc_prdata";
      2:       return "pmu_prdata";
      3:       return "gpio_wic_intr";
      4:       return "rtc_wic_intr";
      5:       return "pmu_wic_intr";
      6:       return "pmu_cpu_dfs_req";
      7:       return "pmu_apb0_pclk_en";
      8:       return "pmu_apb1_pclk_en";
      9:       return "gpio_ioctl_porta_dr";
      10:      return "pad_gpio_oen";
      11:      return "pad_gpio_ien";
      default: return "unknown signal";
    endcase
  endfunction

  always_comb begin
    case (chk_sig)
      0:       watch_val = gpio_prdata;
      1:       watch_val = rtc_prdata;
      2:       watch_val = pmu_prdata;
      3:       watch_val = 32'(gpio_wic_intr);
      4:       watch_val = 32'(rtc_wic_intr);
      5:       watch_val = 32'(pmu_wic_intr);
      6:       watch_val = 32'(pmu_cpu_dfs_req);
      7:       watch_val = 32'(pmu_apb0_pclk_en);
      8:       watch_val = 32'(pmu_apb1_pclk_en);
      9:       watch_val = 32'(gpio_ioctl_porta_dr);
      10:      watch_val = 32'(pad_gpio_oen);
      11:      watch_val = 32'(pad_gpio_ien);
      default: watch_val = '0;
    endcase
  end

  // Sampled on the rising edge, so read data is taken from the access cycle.
  always @(posedge pclk) begin
    if (chk_req) begin
      ok = chk_ge ? (watch_val >= chk_exp) : (watch_val == chk_exp);
      checks++;
      if (ok) begin
        $display("test %0d: %s = 0x%08h ok", chk_id, sig_name(chk_sig), watch_val);
      end else begin
        errors++;
        $display("** Error test %0d: %s = 0x%08h, expected %s0x%08h", chk_id,
                 sig_name(chk_sig), watch_val, chk_ge ? "at least " : "", chk_exp);
      end
    end
  end

  assign n_checks = checks;
  assign n_errors = errors;

endmodule

`default_nettype wire

// ==== tb/aou_tb.sv ====
/*
 * Testbench for the always-on domain: clock, reset, a step table applied
 * in a loop, an APB driver and a Galois LFSR for GPIO input patterns.
 */
`timescale 1ns/100ps
`default_nettype none

module aou_tb;

  localparam int max_cycles = 20000;
  localparam int poll_limit = 200;
  localparam int table_size = 80;

  localparam int s_gpio = 0;                            // Bus slaves. The same codes pick read data.
  localparam int s_rtc  = 1;
  localparam int s_pmu  = 2;

  localparam int pin_ext   = 0;
  localparam int pin_sleep = 1;
  localparam int pin_ack   = 2;

  // Watched outputs are numbered as in the checker.
  localparam int w_gpio_intr = 3;
  localparam int w_rtc_intr  = 4;
  localparam int w_wake_intr = 5;
  localparam int w_dfs_req   = 6;
  localparam int w_apb0_en   = 7;
  localparam int w_apb1_en   = 8;
  localparam int w_porta_dr  = 9;
  localparam int w_oen       = 10;
  localparam int w_ien       = 11;

  typedef enum int {op_wr, op_rd, op_drv, op_obs} op_t;

  typedef struct {
    op_t         op;
    int          tgt;
    int          off;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic        at_least;
    int          gap;
  } step_t;

  logic                       pclk;
  logic                       rst;
  logic [apb_pkg::addr_w-1:0] paddr;
  apb_pkg::data_t             pwdata;
  logic                       pwrite;
  logic                       penable;
  logic                       gpio_psel;
  logic                       rtc_psel;
  logic                       pmu_psel;
  apb_pkg::data_t             gpio_prdata;
  apb_pkg::data_t             rtc_prdata;
  apb_pkg::data_t             pmu_prdata;
  logic [aou_pkg::gpio_w-1:0] ioctl_gpio_ext_porta;
  logic [aou_pkg::gpio_w-1:0] gpio_ioctl_porta_dr;
  logic [aou_pkg::gpio_w-1:0] pad_gpio_oen;
  logic [aou_pkg::gpio_w-1:0] pad_gpio_ien;
  logic                       gpio_wic_intr;
  logic                       rtc_wic_intr;
  logic                       pmu_wic_intr;
  logic                       cpu_pmu_sleep_b;
  logic                       cpu_pmu_dfs_ack;
  logic                       pmu_cpu_dfs_req;
  logic                       pmu_apb0_pclk_en;
  logic                       pmu_apb1_pclk_en;
  logic                       chk_req;
  int                         chk_id;
  int                         chk_sig;
  logic [31:0]                chk_exp;
  logic                       chk_ge;
  logic [31:0]                watch_val;
  int                         n_checks;
  int                         n_errors;
  int                         n_timeouts;
  int                         n_steps;
  step_t                      steps [0:table_size-1];
  logic [15:0]                lfsr;
  logic [31:0]                rnd;

  aou_top dut_i (
    .pclk                 (pclk                ),
    .rst                  (rst                 ),
    .paddr                (paddr               ),
    .pwdata               (pwdata              ),
    .pwrite               (pwrite              ),
    .penable              (penable             ),
    .gpio_psel            (gpio_psel           ),
    .rtc_psel             (rtc_psel            ),
    .pmu_psel             (pmu_psel            ),
    .gpio_prdata          (gpio_prdata         ),
    .rtc_prdata           (rtc_prdata          ),
    .pmu_prdata           (pmu_prdata          ),
    .ioctl_gpio_ext_porta (ioctl_gpio_ext_porta),
    .gpio_ioctl_porta_dr  (gpio_ioctl_porta_dr ),
    .pad_gpio_oen         (pad_gpio_oen        ),
    .pad_gpio_ien         (pad_gpio_ien        ),
    .gpio_wic_intr        (gpio_wic_intr       ),
    .rtc_wic_intr         (rtc_wic_intr        ),
    .pmu_wic_intr         (pmu_wic_intr        ),
    .cpu_pmu_sleep_b      (cpu_pmu_sleep_b     ),
    .cpu_pmu_dfs_ack      (cpu_pmu_dfs_ack     ),
    .pmu_cpu_dfs_req      (pmu_cpu_dfs_req     ),
    .pmu_apb0_pclk_en     (pmu_apb0_pclk_en    ),
    .pmu_apb1_pclk_en     (pmu_apb1_pclk_en    )
  );

  aou_checker chk_i (
    .pclk                (pclk               ),
    .chk_req             (chk_req            ),
    .chk_id              (chk_id             ),
    .chk_sig             (chk_sig            ),
    .chk_exp             (chk_exp            ),
    .chk_ge              (chk_ge             ),
    .gpio_prdata         (gpio_prdata        ),
    .rtc_prdata          (rtc_prdata         ),
    .pmu_prdata          (pmu_prdata         ),
    .gpio_wic_intr       (gpio_wic_intr      ),
    .rtc_wic_intr        (rtc_wic_intr       ),
    .pmu_wic_intr        (pmu_wic_intr       ),
    .pmu_cpu_dfs_req     (pmu_cpu_dfs_req    ),
    .pmu_apb0_pclk_en    (pmu_apb0_pclk_en   ),
    .pmu_apb1_pclk_en    (pmu_apb1_pclk_en   ),
    .gpio_ioctl_porta_dr (gpio_ioctl_porta_dr),
    .pad_gpio_oen        (pad_gpio_oen       ),
    .pad_gpio_ien        (pad_gpio_ien       ),
    .watch_val           (watch_val          ),
    .n_checks            (n_checks           ),
    .n_errors            (n_errors           )
  );

  always #10 pclk = ~pclk;

  // Right-shifting Galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
  endfunction

  task automatic lfsr_word(inout logic [15:0] state, output logic [31:0] word);
    for (int i = 0; i < 32; i++) begin
      word[i] = state[0];
      state   = lfsr_step(state);
    end
  endtask

  task automatic add(input op_t op, input int tgt, input int off, input logic [31:0] wdata,
                     input logic [31:0] exp, input logic at_least, input int gap);
    steps[n_steps] = '{op, tgt, off, wdata, exp, at_least, gap};
    n_steps++;
  endtask

  task automatic build_table();
    // Reset values, then the first offset past each map.
    add(op_obs, w_gpio_intr, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_obs, w_rtc_intr, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_obs, w_wake_intr, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_obs, w_dfs_req, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_obs, w_oen, 0, 32'h0, 32'hffff_ffff, 1'b0, 0);
    add(op_obs, w_ien, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_obs, w_apb0_en, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_obs, w_apb1_en, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_rd, s_gpio, 5, 32'h0, 32'h0, 1'b0, 0);
    add(op_rd, s_rtc, 4, 32'h0, 32'h0, 1'b0, 0);
    add(op_rd, s_pmu, 3, 32'h0, 32'h0, 1'b0, 0);
    add(op_wr, s_gpio, 5, 32'hffff_ffff, 32'h0, 1'b0, 0);
    add(op_rd, s_gpio, aou_pkg::gpio_dr, 32'h0, 32'h0, 1'b0, 0);
    // GPIO data, direction and the synchronized input.
    add(op_wr, s_gpio, aou_pkg::gpio_dr, 32'ha5c3_0f96, 32'h0, 1'b0, 0);
    add(op_obs, w_porta_dr, 0, 32'h0, 32'ha5c3_0f96, 1'b0, 0);
    add(op_wr, s_gpio, aou_pkg::gpio_ddr, 32'h0000_ffff, 32'h0, 1'b0, 0);
    add(op_obs, w_oen, 0, 32'h0, 32'hffff_0000, 1'b0, 0);
    add(op_obs, w_ien, 0, 32'h0, 32'h0000_ffff, 1'b0, 0);
    add(op_rd, s_gpio, aou_pkg::gpio_ddr, 32'h0, 32'h0000_ffff, 1'b0, 0);
    add(op_drv, pin_ext, 0, rnd, 32'h0, 1'b0, 2);
    add(op_rd, s_gpio, aou_pkg::gpio_ext, 32'h0, rnd, 1'b0, 0);
    // Only bit 3 is enabled while bits 3 and 4 both rise.
    add(op_drv, pin_ext, 0, 32'h0, 32'h0, 1'b0, 3);
    add(op_wr, s_gpio, aou_pkg::gpio_inten, 32'h8, 32'h0, 1'b0, 0);
    add(op_drv, pin_ext, 0, 32'h18, 32'h0, 1'b0, 0);
    add(op_obs, w_gpio_intr, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_rd, s_gpio, aou_pkg::gpio_intstat, 32'h0, 32'h8, 1'b0, 0);
    add(op_wr, s_gpio, aou_pkg::gpio_intstat, 32'h8, 32'h0, 1'b0, 0);
    add(op_obs, w_gpio_intr, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_rd, s_gpio, aou_pkg::gpio_intstat, 32'h0, 32'h0, 1'b0, 0);
    // Counter runs from 0 up to a match at 5, with enable and interrupt enable set.
    add(op_wr, s_rtc, aou_pkg::rtc_match, 32'd5, 32'h0, 1'b0, 0);
    add(op_wr, s_rtc, aou_pkg::rtc_count, 32'd0, 32'h0, 1'b0, 0);
    add(op_wr, s_rtc, aou_pkg::rtc_ctrl, 32'h3, 32'h0, 1'b0, 0);
    add(op_obs, w_rtc_intr, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_rd, s_rtc, aou_pkg::rtc_count, 32'h0, 32'd5, 1'b1, 0);
    add(op_rd, s_rtc, aou_pkg::rtc_intstat, 32'h0, 32'h1, 1'b0, 0);
    add(op_wr, s_rtc, aou_pkg::rtc_intstat, 32'h1, 32'h0, 1'b0, 0);
    add(op_obs, w_rtc_intr, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_rd, s_rtc, aou_pkg::rtc_ctrl, 32'h0, 32'h3, 1'b0, 0);
    // PMU clock enables.
    add(op_wr, s_pmu, aou_pkg::pmu_clk_en, 32'h1, 32'h0, 1'b0, 0);
    add(op_obs, w_apb0_en, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_obs, w_apb1_en, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_wr, s_pmu, aou_pkg::pmu_clk_en, 32'h2, 32'h0, 1'b0, 0);
    add(op_obs, w_apb0_en, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_obs, w_apb1_en, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_wr, s_pmu, aou_pkg::pmu_clk_en, 32'h3, 32'h0, 1'b0, 0);
    add(op_rd, s_pmu, aou_pkg::pmu_clk_en, 32'h0, 32'h3, 1'b0, 0);
    // Frequency-change request and acknowledge. Bit 1 reads the request.
    add(op_wr, s_pmu, aou_pkg::pmu_dfs, 32'h1, 32'h0, 1'b0, 0);
    add(op_obs, w_dfs_req, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_rd, s_pmu, aou_pkg::pmu_dfs, 32'h0, 32'h2, 1'b0, 0);
    add(op_drv, pin_ack, 0, 32'h1, 32'h0, 1'b0, 0);
    add(op_obs, w_dfs_req, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_drv, pin_ack, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_rd, s_pmu, aou_pkg::pmu_dfs, 32'h0, 32'h0, 1'b0, 0);
    // A GPIO edge while the CPU sleeps wakes it.
    add(op_drv, pin_sleep, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_drv, pin_ext, 0, 32'h10, 32'h0, 1'b0, 3);
    add(op_drv, pin_ext, 0, 32'h18, 32'h0, 1'b0, 0);
    add(op_obs, w_wake_intr, 0, 32'h0, 32'h1, 1'b0, 0);
    add(op_rd, s_pmu, aou_pkg::pmu_wake, 32'h0, 32'h1, 1'b0, 0);
    add(op_wr, s_gpio, aou_pkg::gpio_intstat, 32'h8, 32'h0, 1'b0, 0);
    add(op_wr, s_pmu, aou_pkg::pmu_wake, 32'h1, 32'h0, 1'b0, 0);
    add(op_obs, w_wake_intr, 0, 32'h0, 32'h0, 1'b0, 0);
    add(op_rd, s_pmu, aou_pkg::pmu_wake, 32'h0, 32'h0, 1'b0, 0);
    add(op_drv, pin_sleep, 0, 32'h1, 32'h0, 1'b0, 0);
  endtask

  // Setup cycle, then access cycle. Read data is checked in the access cycle.
  task automatic bus_xfer(input step_t s, input int id);
    @(negedge pclk);
    paddr     = 32'(s.off) << apb_pkg::reg_lsb;
    pwdata    = s.wdata;
    pwrite    = (s.op == op_wr);
    gpio_psel = (s.tgt == s_gpio);
    rtc_psel  = (s.tgt == s_rtc);
    pmu_psel  = (s.tgt == s_pmu);
    penable   = 1'b0;
    @(negedge pclk);
    penable = 1'b1;
    if (s.op == op_rd) begin
      chk_id  = id;
      chk_sig = s.tgt;
      chk_exp = s.exp;
      chk_ge  = s.at_least;
      chk_req = 1'b1;
    end
    @(negedge pclk);
    gpio_psel = 1'b0;
    rtc_psel  = 1'b0;
    pmu_psel  = 1'b0;
    penable   = 1'b0;
    chk_req   = 1'b0;
  endtask

  task automatic drive_pin(input step_t s);
    @(negedge pclk);
    case (s.tgt)
      pin_ext:   ioctl_gpio_ext_porta = s.wdata;
      pin_sleep: cpu_pmu_sleep_b = s.wdata[0];
      default:   cpu_pmu_dfs_ack = s.wdata[0];
    endcase
  endtask

  // Polls an output until it holds the expected value, then has it checked.
  task automatic watch_output(input step_t s, input int id);
    int   waited;
    logic hit;
    waited = 0;
    @(negedge pclk);
    chk_sig = s.tgt;
    @(negedge pclk);
    hit = s.at_least ? (watch_val >= s.exp) : (watch_val == s.exp);
    while (!hit && waited < poll_limit) begin
      @(negedge pclk);
      waited++;
      hit = s.at_least ? (watch_val >= s.exp) : (watch_val == s.exp);
    end
    if (!hit) begin
      $display("test %0d: timed out after %0d cycles waiting for the output to change",
               id, poll_limit);
      n_timeouts++;
    end
    chk_id  = id;
    chk_exp = s.exp;
    chk_ge  = s.at_least;
    chk_req = 1'b1;
    @(negedge pclk);
    chk_req = 1'b0;
  endtask

  initial begin
    pclk                 = 1'b0;
    rst                  = 1'b1;
    paddr                = '0;
    pwdata               = '0;
    pwrite               = 1'b0;
    penable              = 1'b0;
    gpio_psel            = 1'b0;
    rtc_psel             = 1'b0;
    pmu_psel             = 1'b0;
    ioctl_gpio_ext_porta = '0;
    cpu_pmu_sleep_b      = 1'b1;
    cpu_pmu_dfs_ack      = 1'b0;
    chk_req              = 1'b0;
    chk_id               = 0;
    chk_sig              = 0;
    chk_exp              = '0;
    chk_ge               = 1'b0;
    n_timeouts           = 0;
    n_steps              = 0;
    lfsr                 = 16'd64228;
    lfsr_word(lfsr, rnd);
    build_table();
    repeat (3) @(negedge pclk);
    rst = 1'b0;
    for (int i = 0; i < n_steps; i++) begin
      case (steps[i].op)
        op_wr, op_rd: bus_xfer(steps[i], i);
        op_drv:       drive_pin(steps[i]);
        default:      watch_output(steps[i], i);
      endcase
      repeat (steps[i].gap) @(negedge pclk);
    end
    @(negedge pclk);
    $display("%0d checks, %0d errors, %0d timeouts", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (max_cycles) @(posedge pclk);
    $display("simulation did not finish within %0d cycles", max_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire
